// File: multiface_two.f
+incdir+testbench
src/mf2_pkg.sv
src/mf2_pager.sv
src/mf2_shadow_ram.sv
src/mf2_bus_merge.sv
src/multiface_two.sv
testbench/tb_multiface_two.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --timing --assert -Wall
TOP       := tb_multiface_two
RTL_TOP   := multiface_two
FILELIST  := multiface_two.f
BUILD_DIR := obj_dir
PASS_MSG  := Finished with no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(FLAGS) -j 0 -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: testbench/mf2_cases.txt
# op  addr  data  expect, all hex
# key xnmi fetch iow mode expect paged then nmi nibble; memw expects we; memr expects cpu_din
mode   0000  00  00
key    0000  00  01
fetch  0066  00  10
memw   2345  C3  00
memr   2345  00  C3
memw   4000  77  01
iow    FEEA  00  00
# Snooped while paged out
iow    7F00  03  00
iow    7F00  4A  00
iow    BC00  07  00
iow    BD00  1E  00
iow    FEE8  00  10
memr   3F93  00  4A
memr   3DB7  00  1E
fetch  0065  00  10
iow    FEE8  00  00
# Disabled after reset
mode   0000  02  00
key    0000  00  00
xnmi   0000  01  01
xnmi   0000  00  00

// File: testbench/tb_mf2_checks.svh
`ifndef TB_MF2_CHECKS_SVH
`define TB_MF2_CHECKS_SVH

int check_count = 0;
int error_count = 0;

task automatic check_bit(input string name, input logic got, input logic exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
	end
endtask

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
	end
endtask

// Whole external memory request, field by field in the message
task automatic check_mem(input string name, input mf2_pkg::ext_mem_t got,
		input mf2_pkg::ext_mem_t exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("Error at %0t: %s is oe %b we %b addr %h, expected oe %b we %b addr %h",
			$time, name, got.oe, got.we, got.addr, exp.oe, exp.we, exp.addr);
	end
endtask

`endif

// File: testbench/tb_multiface_two.sv
`timescale 1ns/1ps

module tb_multiface_two;

	localparam int          MAX_CASES   = 64;
	localparam int          CASE_BUDGET = 40; // Cycles per case line
	localparam logic [15:0] PROBE_ADDR  = 16'h0100;
	localparam logic [7:0]  IDLE_EXT    = 8'h5A;

	// Tokens as %s leaves them, right aligned
	localparam logic [63:0] OP_NOTE  = {56'h0, "#"};
	localparam logic [63:0] OP_MODE  = {32'h0, "mode"};
	localparam logic [63:0] OP_KEY   = {40'h0, "key"};
	localparam logic [63:0] OP_XNMI  = {32'h0, "xnmi"};
	localparam logic [63:0] OP_FETCH = {24'h0, "fetch"};
	localparam logic [63:0] OP_IOW   = {40'h0, "iow"};
	localparam logic [63:0] OP_MEMW  = {32'h0, "memw"};
	localparam logic [63:0] OP_MEMR  = {32'h0, "memr"};

	logic               clk_sys = 1'b0;
	logic               reset;
	mf2_pkg::mf2_mode_e mode;
	logic               freeze_key;
	logic               ext_nmi;
	mf2_pkg::cpu_bus_t  bus;
	logic [7:0]         ext_dout;
	mf2_pkg::ext_mem_t  ext_mem;
	logic [7:0]         cpu_din;
	logic               nmi;

	logic [63:0] case_op   [0:MAX_CASES-1];
	logic [15:0] case_addr [0:MAX_CASES-1];
	logic [7:0]  case_data [0:MAX_CASES-1];
	logic [7:0]  case_exp  [0:MAX_CASES-1];
	int          case_total  = 0;
	int          cycle_count = 0;
	int          cycle_limit = CASE_BUDGET;

	`include "tb_mf2_checks.svh"

	multiface_two dut0 (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.mode       (mode),
		.freeze_key (freeze_key),
		.ext_nmi    (ext_nmi),
		.bus        (bus),
		.ext_dout   (ext_dout),
		.ext_mem    (ext_mem),
		.cpu_din    (cpu_din),
		.nmi        (nmi)
	);

	always #4 clk_sys = ~clk_sys; // 8 ns period

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout, run went past %0d cycles", cycle_limit);
			$display("Finished with errors");
			$finish;
		end
	end

	////////////////////////////// Case file

	task automatic load_cases();
		int               fd;
		int               rc;
		logic [63:0]      tok;
		logic [8*128-1:0] rest;
		logic [15:0]      a;
		logic [7:0]       d;
		logic [7:0]       e;
		fd = $fopen("testbench/mf2_cases.txt", "r");
		if (fd == 0) begin
			$display("Case file testbench/mf2_cases.txt could not be opened");
			error_count++;
			return;
		end
		while (!$feof(fd)) begin
			rc = $fscanf(fd, "%s", tok);
			if (rc != 1)
				break;
			if (tok == OP_NOTE) begin
				rc = $fgets(rest, fd); // Rest of a note line
			end else begin
				rc = $fscanf(fd, "%h %h %h", a, d, e);
				if (rc != 3 || case_total >= MAX_CASES) begin
					$display("Case line %0d is malformed or beyond the table", case_total);
					error_count++;
				end else begin
					case_op[case_total]   = tok;
					case_addr[case_total] = a;
					case_data[case_total] = d;
					case_exp[case_total]  = e;
					case_total++;
				end
			end
		end
		$fclose(fd);
		if (case_total == 0) begin
			$display("No cases were read from the case file");
			error_count++;
		end
	endtask

	////////////////////////////// Bus drivers

	// nmi, then the page state through a read in the ROM window
	task automatic check_state(input logic [7:0] exp);
		mf2_pkg::ext_mem_t probe_exp;
		probe_exp.oe = 1'b1;
		probe_exp.we = 1'b0;
		if (exp[4])
			probe_exp.addr = {mf2_pkg::ROM_PAGE, PROBE_ADDR[13:0]}; // Add-on ROM
		else
			probe_exp.addr = {7'h00, PROBE_ADDR};
		@(negedge clk_sys);
		check_bit("nmi", nmi, exp[0]);
		@(posedge clk_sys);
		bus.cpu_addr <= PROBE_ADDR;
		bus.mem_addr <= {7'h00, PROBE_ADDR};
		bus.mem_rd   <= 1'b1;
		@(negedge clk_sys);
		check_mem("ext_mem", ext_mem, probe_exp);
		@(posedge clk_sys);
		bus.mem_rd <= 1'b0;
	endtask

	task automatic run_case(input int idx);
		logic [63:0]       op;
		logic [15:0]       addr;
		logic [7:0]        data;
		logic [7:0]        exp;
		int                errors_before;
		mf2_pkg::ext_mem_t idle_mem;
		op            = case_op[idx];
		addr          = case_addr[idx];
		data          = case_data[idx];
		exp           = case_exp[idx];
		errors_before = error_count;
		idle_mem      = '0;
		@(posedge clk_sys);
		if (op == OP_MODE) begin
			bus      <= '0;
			ext_dout <= IDLE_EXT;
			mode     <= mf2_pkg::mf2_mode_e'(data[1:0]);
			reset    <= 1'b1;
			repeat (2) @(posedge clk_sys);
			reset <= 1'b0;
			@(negedge clk_sys);
			check_mem("ext_mem", ext_mem, idle_mem);
			check_byte("cpu_din", cpu_din, IDLE_EXT); // Idle add-on reads as all ones
			@(posedge clk_sys);
			ext_dout <= 8'hFF;
			check_state(exp);
		end else if (op == OP_KEY || op == OP_FETCH || op == OP_IOW) begin
			bus.cpu_addr <= addr;
			bus.cpu_dout <= data;
			freeze_key   <= (op == OP_KEY);
			bus.m1       <= (op == OP_FETCH);
			bus.io_wr    <= (op == OP_IOW);
			@(posedge clk_sys);
			freeze_key <= 1'b0; // One cycle strobes
			bus.m1     <= 1'b0;
			bus.io_wr  <= 1'b0;
			check_state(exp);
		end else if (op == OP_XNMI) begin
			ext_nmi <= data[0];
			check_state(exp);
		end else if (op == OP_MEMW || op == OP_MEMR) begin
			bus.cpu_addr <= addr;
			bus.mem_addr <= {7'h00, addr};
			bus.cpu_dout <= data;
			bus.mem_wr   <= (op == OP_MEMW);
			bus.mem_rd   <= (op == OP_MEMR);
			if (op == OP_MEMR)
				repeat (2) @(posedge clk_sys); // RAM read latency
			@(negedge clk_sys);
			if (op == OP_MEMW)
				check_bit("ext_mem.we", ext_mem.we, exp[0]);
			else
				check_byte("cpu_din", cpu_din, exp);
			@(posedge clk_sys);
			bus.mem_wr <= 1'b0;
			bus.mem_rd <= 1'b0;
			repeat (2) @(posedge clk_sys);
		end else begin
			$display("Case %0d has an unknown operation", idx);
			error_count++;
		end
		$display("Case %0d at %h: %s", idx, addr, (error_count == errors_before) ? "pass" : "FAIL");
	endtask

	////////////////////////////// Run control

	initial begin
		reset      <= 1'b1;
		mode       <= mf2_pkg::MF2_ENABLED;
		freeze_key <= 1'b0;
		ext_nmi    <= 1'b0;
		bus        <= '0;
		ext_dout   <= 8'hFF;
		load_cases();
		cycle_limit = (case_total + 1) * CASE_BUDGET;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
		for (int i = 0; i < case_total; i++)
			run_case(i);
		$display("Cases %0d, checks %0d, errors %0d", case_total, check_count, error_count);
		if (error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: src/multiface_two.sv
`timescale 1ns/1ps

module multiface_two (
	input  logic               clk_sys,
	input  logic               reset,
	input  mf2_pkg::mf2_mode_e mode,
	input  logic               freeze_key,
	input  logic               ext_nmi,
	input  mf2_pkg::cpu_bus_t  bus,
	input  logic [7:0]         ext_dout,
	output mf2_pkg::ext_mem_t  ext_mem,
	output logic [7:0]         cpu_din,
	output logic               nmi
);

	mf2_pkg::mf2_map_t map;
	logic              nmi_req;
	logic [7:0]        ram_q;

	////////////////////////////// Paging

	mf2_pager u_pager (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.mode       (mode),
		.freeze_key (freeze_key),
		.bus        (bus),
		.map        (map),
		.nmi_req    (nmi_req)
	);

	////////////////////////////// Shadow RAM

	mf2_shadow_ram u_shadow_ram (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (bus),
		.map     (map),
		.ram_q   (ram_q)
	);

	////////////////////////////// Host bus

	mf2_bus_merge u_bus_merge (
		.bus      (bus),
		.map      (map),
		.ram_q    (ram_q),
		.ext_dout (ext_dout),
		.nmi_req  (nmi_req),
		.ext_nmi  (ext_nmi),
		.ext_mem  (ext_mem),
		.cpu_din  (cpu_din),
		.nmi      (nmi)
	);

endmodule

// File: src/mf2_bus_merge.sv
`timescale 1ns/1ps

module mf2_bus_merge (
	input  mf2_pkg::cpu_bus_t bus,
	input  mf2_pkg::mf2_map_t map,
	input  logic [7:0]        ram_q,
	input  logic [7:0]        ext_dout,
	input  logic              nmi_req,
	input  logic              ext_nmi,
	output mf2_pkg::ext_mem_t ext_mem,
	output logic [7:0]        cpu_din,
	output logic              nmi
);

	logic       ram_rd;
	logic [7:0] mf2_dout;

	////////////////////////////// External memory

	// Add-on RAM answers its own reads
	assign ext_mem.oe = bus.mem_rd & ~map.ram_sel;

	// Nothing in the add-on window may reach external memory
	assign ext_mem.we = bus.mem_wr & ~map.ram_sel & ~map.rom_sel;

	always_comb begin
		if (map.rom_sel)
			ext_mem.addr = {mf2_pkg::ROM_PAGE, bus.cpu_addr[13:0]}; // Add-on ROM page
		else
			ext_mem.addr = bus.mem_addr;
	end

	////////////////////////////// Read data

	assign ram_rd   = map.ram_sel & bus.mem_rd;
	assign mf2_dout = ram_rd ? ram_q : 8'hFF; // Idle add-on floats high

	// Open-drain style merge of both sources
	assign cpu_din = ext_dout & mf2_dout;

	assign nmi = nmi_req | ext_nmi;

endmodule

// File: src/mf2_shadow_ram.sv
`timescale 1ns/1ps

module mf2_shadow_ram (
	input  logic              clk_sys,
	input  logic              reset,
	input  mf2_pkg::cpu_bus_t bus,
	input  mf2_pkg::mf2_map_t map,
	output logic [7:0]        ram_q
);

	localparam int AW = mf2_pkg::MF2_RAM_AW;

	logic [7:0] mem [0:(1 << AW) - 1];

	logic          io_wr_prev;
	logic          io_wr_rise;
	logic          snoop_hit;
	logic          cpu_wr;

	mf2_pkg::mf2_data_u data_view;
	logic [7:0]         port;
	logic [AW-1:0]      shadow_addr;

	logic [4:0] pen_idx;  // Last pen selected on the gate array
	logic [3:0] crtc_reg; // Last CRTC register selected

	logic [AW-1:0] ram_a;
	logic [7:0]    ram_d;
	logic          ram_we;

	always_ff @(posedge clk_sys) io_wr_prev <= bus.io_wr;

	assign io_wr_rise = bus.io_wr & ~io_wr_prev;
	assign data_view  = bus.cpu_dout;
	assign port       = bus.cpu_addr[15:8];

	////////////////////////////// Shadow decode

	always_comb begin
		shadow_addr = '0; // Not a snooped port
		case (port)
			mf2_pkg::GA_PORT: begin
				case (data_view.ga.ga_fn)
					mf2_pkg::GA_FN_PEN:   shadow_addr = mf2_pkg::SH_PEN;
					mf2_pkg::GA_FN_COLOR: begin
						// Pen 16 and up is the border
						if (pen_idx[4])
							shadow_addr = mf2_pkg::SH_BORDER;
						else
							shadow_addr = {mf2_pkg::SH_PEN_BASE, pen_idx[3:0]};
					end
					mf2_pkg::GA_FN_MODE:  shadow_addr = mf2_pkg::SH_MODE;
					mf2_pkg::GA_FN_BANK:  shadow_addr = mf2_pkg::SH_BANK;
					default:              shadow_addr = '0;
				endcase
			end
			mf2_pkg::CRTC_SEL_PORT: shadow_addr = mf2_pkg::SH_CRTC_SEL;
			mf2_pkg::CRTC_VAL_PORT: shadow_addr = {mf2_pkg::SH_CRTC_BASE, crtc_reg};
			mf2_pkg::PPI_PORT:      shadow_addr = mf2_pkg::SH_PPI;
			mf2_pkg::ROMSEL_PORT:   shadow_addr = mf2_pkg::SH_ROMSEL; // Upper ROM number
			default:                shadow_addr = '0;
		endcase
	end

	assign snoop_hit = io_wr_rise && (shadow_addr != '0);
	assign cpu_wr    = bus.mem_wr && map.ram_sel;

	////////////////////////////// Index capture

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pen_idx  <= '0;
			crtc_reg <= '0;
		end else if (snoop_hit) begin
			if (port == mf2_pkg::GA_PORT && data_view.ga.ga_fn == mf2_pkg::GA_FN_PEN)
				pen_idx <= data_view.ga.ga_arg[4:0];
			if (port == mf2_pkg::CRTC_SEL_PORT)
				crtc_reg <= data_view.crtc.crtc_reg;
		end
	end

	////////////////////////////// Access request

	// Snooped writes win over CPU access
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ram_we <= 1'b0;
		end else begin
			ram_we <= snoop_hit || cpu_wr;
		end
	end

	always_ff @(posedge clk_sys) begin
		ram_d <= bus.cpu_dout;
		if (snoop_hit)
			ram_a <= shadow_addr;
		else
			ram_a <= bus.mem_addr[AW-1:0]; // CPU write or plain read
	end

	////////////////////////////// 8 KB RAM

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mem[ram_a] <= ram_d;
			ram_q      <= ram_d; // Write-through
		end else begin
			ram_q <= mem[ram_a];
		end
	end

	// A RAM write is always caused by the cycle before
	a_write_cause: assert property (
		@(posedge clk_sys) disable iff (reset)
		ram_we |-> $past(snoop_hit || cpu_wr)
	);

endmodule

// File: src/mf2_pager.sv
`timescale 1ns/1ps

module mf2_pager (
	input  logic               clk_sys,
	input  logic               reset,
	input  mf2_pkg::mf2_mode_e mode,
	input  logic               freeze_key,
	input  mf2_pkg::cpu_bus_t  bus,
	output mf2_pkg::mf2_map_t  map,
	output logic               nmi_req
);

	logic key_prev;
	logic m1_prev;
	logic io_wr_prev;

	logic nmi_armed;
	logic paged;
	logic hidden;

	logic key_rise;
	logic m1_rise;
	logic io_wr_rise;
	logic ctrl_hit;
	logic disabled;

	////////////////////////////// Edge detect

	// Strobe levels from the cycle before
	always_ff @(posedge clk_sys) begin
		key_prev   <= freeze_key;
		m1_prev    <= bus.m1;
		io_wr_prev <= bus.io_wr;
	end

	assign key_rise   = freeze_key & ~key_prev;
	assign m1_rise    = bus.m1 & ~m1_prev;
	assign io_wr_rise = bus.io_wr & ~io_wr_prev;

	assign disabled = (mode == mf2_pkg::MF2_DISABLED);
	assign ctrl_hit = io_wr_rise && (bus.cpu_addr[15:2] == mf2_pkg::MF2_CTRL_PORT);

	////////////////////////////// Paging state

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			nmi_armed <= 1'b0;
			paged     <= 1'b0;
			hidden    <= (mode != mf2_pkg::MF2_ENABLED);
		end else begin
			if (key_rise && !paged && !disabled)
				nmi_armed <= 1'b1; // Freeze button

			// NMI acknowledge fetch
			if (nmi_armed && m1_rise && bus.cpu_addr == mf2_pkg::MF2_NMI_VEC) begin
				paged     <= 1'b1;
				hidden    <= 1'b0;
				nmi_armed <= 1'b0;
			end

			if (paged && m1_rise && bus.cpu_addr == mf2_pkg::MF2_HIDE_VEC)
				hidden <= 1'b1;

			// FEE8 pages in, FEEA pages out
			if (ctrl_hit)
				paged <= ~bus.cpu_addr[1] & ~hidden & ~disabled;
		end
	end

	////////////////////////////// Window decode

	assign map.paged   = paged;
	assign map.rom_sel = paged && (bus.cpu_addr[15:13] == mf2_pkg::MF2_ROM_WIN);
	assign map.ram_sel = paged && (bus.cpu_addr[15:13] == mf2_pkg::MF2_RAM_WIN);

	assign nmi_req = nmi_armed;

	// ROM and RAM windows are disjoint
	a_sel_onehot: assert property (
		@(posedge clk_sys) disable iff (reset)
		!(map.rom_sel && map.ram_sel)
	);

endmodule

// File: src/mf2_pkg.sv
package mf2_pkg;

	////////////////////////////// Sizes and vectors

	localparam int MF2_RAM_AW = 13; // 8 KB add-on RAM

	localparam logic [15:0] MF2_NMI_VEC  = 16'h0066; // NMI fetch pages in
	localparam logic [15:0] MF2_HIDE_VEC = 16'h0065; // Fetch here hides the add-on

	// 0xFEE8 / 0xFEEA share everything above bit 1
	localparam logic [13:0] MF2_CTRL_PORT = 14'b11111110111010;

	localparam logic [8:0] ROM_PAGE = 9'h0FF; // Add-on ROM page in external memory

	// CPU address windows, top three address bits
	localparam logic [2:0] MF2_ROM_WIN = 3'b000; // 0x0000-0x1FFF
	localparam logic [2:0] MF2_RAM_WIN = 3'b001; // 0x2000-0x3FFF

	////////////////////////////// Snooped ports

	localparam logic [7:0] GA_PORT       = 8'h7F;
	localparam logic [7:0] CRTC_SEL_PORT = 8'hBC;
	localparam logic [7:0] CRTC_VAL_PORT = 8'hBD;
	localparam logic [7:0] PPI_PORT      = 8'hF7;
	localparam logic [7:0] ROMSEL_PORT   = 8'hDF;

	// Gate array command classes, top two data bits
	localparam logic [1:0] GA_FN_PEN   = 2'b00;
	localparam logic [1:0] GA_FN_COLOR = 2'b01;
	localparam logic [1:0] GA_FN_MODE  = 2'b10;
	localparam logic [1:0] GA_FN_BANK  = 2'b11;

	////////////////////////////// Shadow locations

	localparam logic [12:0] SH_PEN       = 13'h1FCF;
	localparam logic [12:0] SH_BORDER    = 13'h1FDF;
	localparam logic [8:0]  SH_PEN_BASE  = 9'h1F9;  // Plus pen index
	localparam logic [12:0] SH_MODE      = 13'h1FEF;
	localparam logic [12:0] SH_BANK      = 13'h1FFF;
	localparam logic [12:0] SH_CRTC_SEL  = 13'h1CFF;
	localparam logic [8:0]  SH_CRTC_BASE = 9'h1DB;  // Plus CRTC register
	localparam logic [12:0] SH_PPI       = 13'h17FF;
	localparam logic [12:0] SH_ROMSEL    = 13'h1AAC;

	////////////////////////////// Types

	// Host CPU bus, all strobes are levels
	typedef struct packed {
		logic [15:0] cpu_addr;
		logic [7:0]  cpu_dout;
		logic [22:0] mem_addr;
		logic        m1;
		logic        io_wr;
		logic        mem_rd;
		logic        mem_wr;
	} cpu_bus_t;

	// Data byte of an I/O write, seen by the gate array or the CRTC
	typedef union packed {
		struct packed {
			logic [1:0] ga_fn;
			logic [5:0] ga_arg; // Pen index in low 5 bits
		} ga;
		struct packed {
			logic [3:0] rsvd;
			logic [3:0] crtc_reg;
		} crtc;
	} mf2_data_u;

	typedef struct packed {
		logic rom_sel;
		logic ram_sel;
		logic paged;
	} mf2_map_t;

	typedef enum logic [1:0] {
		MF2_ENABLED  = 2'd0,
		MF2_HIDDEN   = 2'd1,
		MF2_DISABLED = 2'd2
	} mf2_mode_e;

	typedef struct packed {
		logic        oe;
		logic        we;
		logic [22:0] addr;
	} ext_mem_t;

endpackage
